// ==== source/sam_pkg.sv ====
// Shared widths, constants and enums; the port enum names only the ports this block decodes
`default_nettype none

package sam_pkg;

	// ============================================================
	// Bus and memory widths
	// ============================================================
	localparam int DATA_W     = 8;                  // CPU data bus
	localparam int ADDR_W     = 16;                 // CPU address bus
	localparam int OFFSET_W   = 14;                 // Offset inside a 16 KB page
	localparam int PAGE_W     = 9;
	localparam int RAM_ADDR_W = PAGE_W + OFFSET_W;  // Page and offset

	// Fixed page numbers
	localparam logic [PAGE_W-1:0] ROM_PAGE_BASE = 9'h1FE;  // ROM0, ROM1 sits one above
	localparam logic [PAGE_W-1:0] EXT_PAGE_BASE = 9'h040;  // Start of external RAM

	// ============================================================
	// MIDI timing
	// ============================================================
	localparam int CE_1M_DIV  = 96;                 // System clocks per 1 MHz tick
	localparam int CE_1M_W    = $clog2(CE_1M_DIV);
	localparam int MIDI_CNT_W = 9;

	localparam logic [MIDI_CNT_W-1:0] MIDI_TX_TICKS = 9'd320;  // One byte on the wire
	localparam logic [MIDI_CNT_W-1:0] MIDI_IRQ_TICK = 9'd15;

	// Audio mix
	localparam int AUDIO_W = 9;
	localparam logic [AUDIO_W-1:0] EAR_LEVEL = 9'h100;

	// ============================================================
	// Enums
	// ============================================================
	// Low byte of the I/O address, only the decoded ones
	typedef enum logic [7:0] {
		PORT_NONE       = 8'd0,    // Anything not decoded
		PORT_EXT_C      = 8'd128,
		PORT_EXT_D      = 8'd129,
		PORT_LPT_DATA   = 8'd232,
		PORT_LPT_STROBE = 8'd233,
		PORT_STATUS     = 8'd249,
		PORT_LMPR       = 8'd250,
		PORT_HMPR       = 8'd251,
		PORT_MIDI       = 8'd253,
		PORT_BORDER     = 8'd254
	} port_addr_t;

	typedef enum logic [1:0] {
		MIDI_IDLE = 2'd0,
		MIDI_SEND = 2'd1,
		MIDI_IRQ  = 2'd2   // Last ticks of a byte, interrupt raised
	} midi_state_t;

endpackage

`default_nettype wire

// ==== source/sam_bus_port.sv ====
// One transaction at a time over req/ack; requester holds address and data stable until io_ack
`timescale 1ns/1ps
`default_nettype none

module sam_bus_port (
	input  wire                             clk_sys,
	input  wire                             reset,
	input  wire                             io_req,
	input  wire                             io_write,
	input  wire  [sam_pkg::ADDR_W-1:0]      io_addr,
	input  wire  [sam_pkg::DATA_W-1:0]      io_wdata,
	output logic                            io_ack,
	output logic [sam_pkg::DATA_W-1:0]      io_rdata,
	output logic                            wr_stb,
	output sam_pkg::port_addr_t             wr_port,
	output logic [sam_pkg::DATA_W-1:0]      wr_data,
	input  wire  [sam_pkg::DATA_W-1:0]      lmpr,
	input  wire  [sam_pkg::DATA_W-1:0]      hmpr,
	input  wire                             int_midi
);

	sam_pkg::port_addr_t         port_sel;
	logic [sam_pkg::DATA_W-1:0]  rd_value;
	logic                        accept;

	assign accept = io_req & ~io_ack;  // First cycle of a new request

	// ============================================================
	// Port decode, low address byte only
	// ============================================================
	always_comb begin
		case (io_addr[7:0])
			sam_pkg::PORT_EXT_C:      port_sel = sam_pkg::PORT_EXT_C;
			sam_pkg::PORT_EXT_D:      port_sel = sam_pkg::PORT_EXT_D;
			sam_pkg::PORT_LPT_DATA:   port_sel = sam_pkg::PORT_LPT_DATA;
			sam_pkg::PORT_LPT_STROBE: port_sel = sam_pkg::PORT_LPT_STROBE;
			sam_pkg::PORT_STATUS:     port_sel = sam_pkg::PORT_STATUS;
			sam_pkg::PORT_LMPR:       port_sel = sam_pkg::PORT_LMPR;
			sam_pkg::PORT_HMPR:       port_sel = sam_pkg::PORT_HMPR;
			sam_pkg::PORT_MIDI:       port_sel = sam_pkg::PORT_MIDI;
			sam_pkg::PORT_BORDER:     port_sel = sam_pkg::PORT_BORDER;
			default:                  port_sel = sam_pkg::PORT_NONE;
		endcase
	end

	// Read mux
	always_comb begin
		case (port_sel)
			sam_pkg::PORT_STATUS:     rd_value = {3'b111, ~int_midi, 4'b1111};  // Line/frame inactive
			sam_pkg::PORT_LMPR:       rd_value = lmpr;
			sam_pkg::PORT_HMPR:       rd_value = hmpr;
			sam_pkg::PORT_LPT_DATA,
			sam_pkg::PORT_LPT_STROBE: rd_value = '0;     // Printer port reads as zero
			default:                  rd_value = 8'hFF;  // Open bus
		endcase
	end

	// ============================================================
	// Handshake and write strobe
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_ack   <= 1'b0;
			io_rdata <= '0;
			wr_stb   <= 1'b0;
			wr_port  <= sam_pkg::PORT_NONE;
			wr_data  <= '0;
		end else begin
			wr_stb <= accept & io_write;  // Same cycle as the ack edge
			if (accept) begin
				io_ack   <= 1'b1;
				io_rdata <= rd_value;
				wr_port  <= port_sel;
				wr_data  <= io_wdata;
			end else if (!io_req) begin
				io_ack <= 1'b0;  // Return to zero phase
			end
		end
	end

	// Ack only ever answers a live request
	assert property (@(posedge clk_sys) disable iff (reset)
		$rose(io_ack) |-> $past(io_req));

endmodule

`default_nettype wire

// ==== source/sam_mem_pager.sv ====
// Paging registers and combinational address translation; section B and D pages wrap within 32
`timescale 1ns/1ps
`default_nettype none

module sam_mem_pager (
	input  wire                             clk_sys,
	input  wire                             reset,
	input  wire                             wr_stb,
	input  wire  sam_pkg::port_addr_t       wr_port,
	input  wire  [sam_pkg::DATA_W-1:0]      wr_data,
	input  wire  [sam_pkg::ADDR_W-1:0]      mem_addr,
	output logic [sam_pkg::RAM_ADDR_W-1:0]  ram_addr,
	output logic                            mem_rom,
	output logic                            mem_wp,
	output logic [sam_pkg::DATA_W-1:0]      lmpr,
	output logic [sam_pkg::DATA_W-1:0]      hmpr
);

	logic [sam_pkg::DATA_W-1:0]  ext_c;
	logic [sam_pkg::DATA_W-1:0]  ext_d;
	logic [1:0]                  section;   // 16 KB quarter of the CPU map
	logic                        rom_sel;
	logic                        ext_sel;
	logic [4:0]                  page_b;
	logic [4:0]                  page_d;
	logic [sam_pkg::PAGE_W-1:0]  page;

	// ============================================================
	// Registers
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			lmpr  <= '0;
			hmpr  <= '0;
			ext_c <= '0;
			ext_d <= '0;
		end else if (wr_stb) begin
			case (wr_port)
				sam_pkg::PORT_LMPR:  lmpr  <= wr_data;
				sam_pkg::PORT_HMPR:  hmpr  <= wr_data;
				sam_pkg::PORT_EXT_C: ext_c <= wr_data;
				sam_pkg::PORT_EXT_D: ext_d <= wr_data;
				default: ;
			endcase
		end
	end

	// ============================================================
	// Translation
	// ============================================================
	assign section = mem_addr[sam_pkg::ADDR_W-1 -: 2];
	assign rom_sel = (~lmpr[5] & (section == 2'd0)) | (lmpr[6] & (section == 2'd3));
	assign ext_sel = ~rom_sel & hmpr[7] & mem_addr[sam_pkg::ADDR_W-1];  // ROM wins over window
	assign page_b  = lmpr[4:0] + 5'd1;
	assign page_d  = hmpr[4:0] + 5'd1;

	always_comb begin
		if (rom_sel) begin
			page = sam_pkg::ROM_PAGE_BASE
				+ {{(sam_pkg::PAGE_W-1){1'b0}}, mem_addr[sam_pkg::ADDR_W-1]};
		end else if (ext_sel) begin
			page = sam_pkg::EXT_PAGE_BASE
				+ {{(sam_pkg::PAGE_W-sam_pkg::DATA_W){1'b0}}, (section[0] ? ext_d : ext_c)};
		end else begin
			case (section)
				2'd0:    page = {{(sam_pkg::PAGE_W-5){1'b0}}, lmpr[4:0]};
				2'd1:    page = {{(sam_pkg::PAGE_W-5){1'b0}}, page_b};
				2'd2:    page = {{(sam_pkg::PAGE_W-5){1'b0}}, hmpr[4:0]};
				default: page = {{(sam_pkg::PAGE_W-5){1'b0}}, page_d};
			endcase
		end
	end

	assign ram_addr = {page, mem_addr[sam_pkg::OFFSET_W-1:0]};
	assign mem_rom  = rom_sel;
	assign mem_wp   = rom_sel | (lmpr[7] & (section == 2'd0));  // ROM is never writable

	// ROM pages sit above every RAM and external window page
	assert property (@(posedge clk_sys) disable iff (reset)
		mem_rom == (ram_addr[sam_pkg::RAM_ADDR_W-1 -: sam_pkg::PAGE_W]
			>= sam_pkg::ROM_PAGE_BASE));

endmodule

`default_nettype wire

// ==== source/sam_sound_ports.sv ====
// Border and printer-port voice; audio outputs are unsigned and lag a register write by one cycle
`timescale 1ns/1ps
`default_nettype none

module sam_sound_ports (
	input  wire                             clk_sys,
	input  wire                             reset,
	input  wire                             wr_stb,
	input  wire  sam_pkg::port_addr_t       wr_port,
	input  wire  [sam_pkg::DATA_W-1:0]      wr_data,
	output logic [3:0]                      border_color,
	output logic [sam_pkg::AUDIO_W-1:0]     audio_l,
	output logic [sam_pkg::AUDIO_W-1:0]     audio_r
);

	logic                        ear;        // Border bit 4
	logic                        strobe_q;   // Last strobe level written
	logic [sam_pkg::DATA_W-1:0]  lpt_data;
	logic [sam_pkg::DATA_W-1:0]  vox_l;
	logic [sam_pkg::DATA_W-1:0]  vox_r;
	logic [sam_pkg::AUDIO_W-1:0] ear_add;

	// ============================================================
	// Port registers
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= '0;
			ear          <= 1'b0;
			strobe_q     <= 1'b0;
			lpt_data     <= '0;
			vox_l        <= '0;
			vox_r        <= '0;
		end else if (wr_stb) begin
			case (wr_port)
				sam_pkg::PORT_BORDER: begin
					border_color <= {wr_data[5], wr_data[2:0]};
					ear          <= wr_data[4];
				end
				sam_pkg::PORT_LPT_DATA: lpt_data <= wr_data;
				sam_pkg::PORT_LPT_STROBE: begin
					// Rising edge feeds left, falling edge feeds right
					if (!strobe_q && wr_data[0])
						vox_l <= lpt_data;
					if (strobe_q && !wr_data[0])
						vox_r <= lpt_data;
					strobe_q <= wr_data[0];
				end
				default: ;
			endcase
		end
	end

	// Audio mix
	assign ear_add = ear ? sam_pkg::EAR_LEVEL : '0;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_l <= '0;
			audio_r <= '0;
		end else begin
			audio_l <= {1'b0, vox_l} + ear_add;  // Voice max 255, no overflow
			audio_r <= {1'b0, vox_r} + ear_add;
		end
	end

endmodule

`default_nettype wire

// ==== source/sam_midi_tx.sv ====
// MIDI transmit timer only, no serial line; a write during a byte queues exactly one more byte
`timescale 1ns/1ps
`default_nettype none

module sam_midi_tx (
	input  wire                         clk_sys,
	input  wire                         reset,
	input  wire                         wr_stb,
	input  wire  sam_pkg::port_addr_t   wr_port,
	output logic                        midi_busy,
	output logic                        int_midi
);

	logic [sam_pkg::CE_1M_W-1:0]     div_cnt;
	logic                            tick;      // 1 MHz enable
	logic                            pending;   // Byte written, not yet started
	logic [sam_pkg::MIDI_CNT_W-1:0]  tx_cnt;
	sam_pkg::midi_state_t            state;

	assign tick = (div_cnt == sam_pkg::CE_1M_W'(sam_pkg::CE_1M_DIV - 1));

	// ============================================================
	// Divider and transmit FSM
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			div_cnt <= '0;
			pending <= 1'b0;
			tx_cnt  <= '0;
			state   <= sam_pkg::MIDI_IDLE;
		end else begin
			div_cnt <= tick ? '0 : div_cnt + 1'b1;

			if (tick) begin
				case (state)
					sam_pkg::MIDI_IDLE: if (pending) begin
						state   <= sam_pkg::MIDI_SEND;
						tx_cnt  <= sam_pkg::MIDI_TX_TICKS;
						pending <= 1'b0;
					end
					sam_pkg::MIDI_SEND: begin
						tx_cnt <= tx_cnt - 1'b1;
						// Interrupt rises as the count lands on the IRQ tick
						if (tx_cnt == sam_pkg::MIDI_IRQ_TICK + 1'b1)
							state <= sam_pkg::MIDI_IRQ;
					end
					sam_pkg::MIDI_IRQ: begin
						if (tx_cnt == '0)
							state <= sam_pkg::MIDI_IDLE;  // Drops busy and int together
						else
							tx_cnt <= tx_cnt - 1'b1;
					end
					default: state <= sam_pkg::MIDI_IDLE;
				endcase
			end

			// New write wins over the start clear
			if (wr_stb && wr_port == sam_pkg::PORT_MIDI)
				pending <= 1'b1;
		end
	end

	assign midi_busy = (state != sam_pkg::MIDI_IDLE);
	assign int_midi  = (state == sam_pkg::MIDI_IRQ);

	// Interrupt only late in a byte already in flight
	assert property (@(posedge clk_sys) disable iff (reset)
		$rose(int_midi) |-> $past(midi_busy));

	// A byte always ends through the interrupt phase
	assert property (@(posedge clk_sys) disable iff (reset)
		$fell(midi_busy) |-> $past(int_midi));

endmodule

`default_nettype wire

// ==== source/sam_asic.sv ====
// I/O port block top; CPU, video, disks and sound chips live outside this block
`timescale 1ns/1ps
`default_nettype none

module sam_asic (
	input  wire                             clk_sys,
	input  wire                             reset,
	// Port bus
	input  wire                             io_req,
	input  wire                             io_write,
	input  wire  [sam_pkg::ADDR_W-1:0]      io_addr,
	input  wire  [sam_pkg::DATA_W-1:0]      io_wdata,
	output logic                            io_ack,
	output logic [sam_pkg::DATA_W-1:0]      io_rdata,
	// Memory side
	input  wire  [sam_pkg::ADDR_W-1:0]      mem_addr,
	output logic [sam_pkg::RAM_ADDR_W-1:0]  ram_addr,
	output logic                            mem_rom,
	output logic                            mem_wp,
	// Border, audio, MIDI
	output logic [3:0]                      border_color,
	output logic [sam_pkg::AUDIO_W-1:0]     audio_l,
	output logic [sam_pkg::AUDIO_W-1:0]     audio_r,
	output logic                            midi_busy,
	output logic                            int_midi
);

	logic                        wr_stb;
	sam_pkg::port_addr_t         wr_port;
	logic [sam_pkg::DATA_W-1:0]  wr_data;
	logic [sam_pkg::DATA_W-1:0]  lmpr;
	logic [sam_pkg::DATA_W-1:0]  hmpr;

	sam_bus_port bus_port_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.io_req   (io_req),
		.io_write (io_write),
		.io_addr  (io_addr),
		.io_wdata (io_wdata),
		.io_ack   (io_ack),
		.io_rdata (io_rdata),
		.wr_stb   (wr_stb),
		.wr_port  (wr_port),
		.wr_data  (wr_data),
		.lmpr     (lmpr),
		.hmpr     (hmpr),
		.int_midi (int_midi)
	);

	sam_mem_pager mem_pager_i (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.wr_stb   (wr_stb),
		.wr_port  (wr_port),
		.wr_data  (wr_data),
		.mem_addr (mem_addr),
		.ram_addr (ram_addr),
		.mem_rom  (mem_rom),
		.mem_wp   (mem_wp),
		.lmpr     (lmpr),
		.hmpr     (hmpr)
	);

	sam_sound_ports sound_ports_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.wr_stb       (wr_stb),
		.wr_port      (wr_port),
		.wr_data      (wr_data),
		.border_color (border_color),
		.audio_l      (audio_l),
		.audio_r      (audio_r)
	);

	sam_midi_tx midi_tx_i (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.wr_stb    (wr_stb),
		.wr_port   (wr_port),
		.midi_busy (midi_busy),
		.int_midi  (int_midi)
	);

endmodule

`default_nettype wire

// ==== dv/sam_asic_tb.sv ====
// Directed tests of the port block; package and RTL compile first, and any timeout ends the run
`timescale 1ns/1ps
`default_nettype none

module sam_asic_tb;

	localparam int ACK_WAIT  = 100;    // Cycles allowed per handshake phase
	localparam int MIDI_WAIT = 40000;

	logic                                clk_sys;
	logic                                reset;
	logic                                io_req;
	logic                                io_write;
	logic [sam_pkg::ADDR_W-1:0]          io_addr;
	logic [sam_pkg::DATA_W-1:0]          io_wdata;
	wire                                 io_ack;
	wire  [sam_pkg::DATA_W-1:0]          io_rdata;
	logic [sam_pkg::ADDR_W-1:0]          mem_addr;
	wire  [sam_pkg::RAM_ADDR_W-1:0]      ram_addr;
	wire                                 mem_rom;
	wire                                 mem_wp;
	wire  [3:0]                          border_color;
	wire  [sam_pkg::AUDIO_W-1:0]         audio_l;
	wire  [sam_pkg::AUDIO_W-1:0]         audio_r;
	wire                                 midi_busy;
	wire                                 int_midi;

	logic [16:0]  lfsr;
	int           check_count;
	int           err_count;
	int           test_count;
	int           test_errs;   // err_count when the current test began
	string        cur_test;

	sam_asic dut_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.io_req       (io_req),
		.io_write     (io_write),
		.io_addr      (io_addr),
		.io_wdata     (io_wdata),
		.io_ack       (io_ack),
		.io_rdata     (io_rdata),
		.mem_addr     (mem_addr),
		.ram_addr     (ram_addr),
		.mem_rom      (mem_rom),
		.mem_wp       (mem_wp),
		.border_color (border_color),
		.audio_l      (audio_l),
		.audio_r      (audio_r),
		.midi_busy    (midi_busy),
		.int_midi     (int_midi)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ============================================================
	// Stimulus helpers
	// ============================================================
	// 17-bit Fibonacci LFSR, taps 17 and 14
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic rand_bits(input int n, output logic [15:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val  = {val[14:0], lfsr[0]};  // One step per bit
		end
	endtask

	task automatic rand_byte(output logic [7:0] b);
		logic [15:0] v;
		rand_bits(8, v);
		b = v[7:0];
	endtask

	task automatic abort_run(input string why);
		$display("ERROR: %s", why);
		$display("Simulation finished: FAIL");
		$finish;
	endtask

	task automatic wait_ack(input logic level, input string why);
		int n;
		n = 0;
		while (io_ack !== level && n < ACK_WAIT) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		if (io_ack !== level)
			abort_run(why);
	endtask

	// Both bus tasks start and end 1 ns after a rising edge
	task automatic port_write(input logic [7:0] port, input logic [7:0] data);
		io_req   = 1'b1;
		io_write = 1'b1;
		io_addr  = {8'hFE, port};  // High byte is ignored by decode
		io_wdata = data;
		wait_ack(1'b1, "io_ack never rose for a port write");
		io_req = 1'b0;
		wait_ack(1'b0, "io_ack stayed high after a port write");
		@(posedge clk_sys);  // Registered audio lags one more cycle
		#1;
	endtask

	task automatic port_read(input logic [7:0] port, output logic [7:0] data);
		io_req   = 1'b1;
		io_write = 1'b0;
		io_addr  = {8'hFE, port};
		wait_ack(1'b1, "io_ack never rose for a port read");
		data   = io_rdata;
		io_req = 1'b0;
		wait_ack(1'b0, "io_ack stayed high after a port read");
	endtask

	// ============================================================
	// Compare tasks
	// ============================================================
	task automatic check_byte(input string what, input logic [sam_pkg::DATA_W-1:0] exp,
			input logic [sam_pkg::DATA_W-1:0] act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_ram_addr(input string what, input logic [sam_pkg::RAM_ADDR_W-1:0] exp,
			input logic [sam_pkg::RAM_ADDR_W-1:0] act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_flag(input string what, input logic exp, input logic act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act);
		end
	endtask

	task automatic check_audio(input string what, input logic [sam_pkg::AUDIO_W-1:0] exp,
			input logic [sam_pkg::AUDIO_W-1:0] act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	// Random offset in one section, page and flags checked
	task automatic check_mem(input logic [1:0] sec, input logic [sam_pkg::PAGE_W-1:0] page,
			input logic rom, input logic wp);
		logic [15:0] r;
		rand_bits(sam_pkg::OFFSET_W, r);
		mem_addr = {sec, r[13:0]};
		#1;
		check_ram_addr("ram_addr", {page, r[13:0]}, ram_addr);
		check_flag("mem_rom", rom, mem_rom);
		check_flag("mem_wp", wp, mem_wp);
		@(posedge clk_sys);
		#1;
	endtask

	task automatic start_test(input string name);
		cur_test  = name;
		test_errs = err_count;
		test_count++;
	endtask

	task automatic end_test();
		if (err_count == test_errs)
			$display("%s: ok", cur_test);
		else
			$display("%s: %0d errors", cur_test, err_count - test_errs);
	endtask

	// ============================================================
	// Tests
	// ============================================================
	task automatic test_reset_state();
		logic [7:0] d;
		start_test("reset_state");
		port_read(sam_pkg::PORT_LMPR, d);
		check_byte("lmpr", 8'h00, d);
		port_read(sam_pkg::PORT_HMPR, d);
		check_byte("hmpr", 8'h00, d);
		port_read(8'h34, d);
		check_byte("undecoded port", 8'hFF, d);
		check_flag("midi_busy", 1'b0, midi_busy);
		check_flag("int_midi", 1'b0, int_midi);
		end_test();
	endtask

	task automatic test_ram_paging();
		logic [7:0] l;
		logic [7:0] h;
		logic [7:0] d;
		logic [4:0] pb;
		logic [4:0] pd;
		start_test("ram_paging");
		rand_byte(l);
		rand_byte(h);
		l  = (l | 8'h20) & 8'hBF;  // Both ROMs off
		h  = h & 8'h7F;            // No external window
		pb = l[4:0] + 5'd1;        // Wraps inside 32 pages
		pd = h[4:0] + 5'd1;
		port_write(sam_pkg::PORT_LMPR, l);
		port_write(sam_pkg::PORT_HMPR, h);
		port_read(sam_pkg::PORT_LMPR, d);
		check_byte("lmpr readback", l, d);
		port_read(sam_pkg::PORT_HMPR, d);
		check_byte("hmpr readback", h, d);
		check_mem(2'd0, {4'b0, l[4:0]}, 1'b0, l[7]);
		check_mem(2'd1, {4'b0, pb}, 1'b0, 1'b0);
		check_mem(2'd2, {4'b0, h[4:0]}, 1'b0, 1'b0);
		check_mem(2'd3, {4'b0, pd}, 1'b0, 1'b0);
		end_test();
	endtask

	task automatic test_rom_select();
		logic [7:0] l;
		start_test("rom_select");
		rand_byte(l);
		l = l & 8'hDF;  // ROM0 on
		port_write(sam_pkg::PORT_LMPR, l);
		check_mem(2'd0, 9'h1FE, 1'b1, 1'b1);
		l = l | 8'h60;  // ROM1 on, ROM0 off
		port_write(sam_pkg::PORT_LMPR, l);
		check_mem(2'd3, 9'h1FF, 1'b1, 1'b1);
		l = (l | 8'hA0) & 8'hBF;  // Protected RAM in section A
		port_write(sam_pkg::PORT_LMPR, l);
		check_mem(2'd0, {4'b0, l[4:0]}, 1'b0, 1'b1);
		end_test();
	endtask

	task automatic test_ext_window();
		logic [7:0] c;
		logic [7:0] d;
		logic [7:0] h;
		start_test("ext_window");
		rand_byte(c);
		rand_byte(d);
		rand_byte(h);
		h = h | 8'h80;
		port_write(sam_pkg::PORT_EXT_C, c);
		port_write(sam_pkg::PORT_EXT_D, d);
		port_write(sam_pkg::PORT_HMPR, h);
		port_write(sam_pkg::PORT_LMPR, 8'h20);  // Keep ROM1 out of section D
		check_mem(2'd2, 9'h040 + {1'b0, c}, 1'b0, 1'b0);
		check_mem(2'd3, 9'h040 + {1'b0, d}, 1'b0, 1'b0);
		end_test();
	endtask

	task automatic test_border_audio();
		logic [7:0] b;
		logic [7:0] v1;
		logic [7:0] v2;
		start_test("border_audio");
		rand_byte(b);
		b = b | 8'h10;  // Ear on
		port_write(sam_pkg::PORT_BORDER, b);
		check_byte("border_color", {4'b0, b[5], b[2:0]}, {4'b0, border_color});
		check_audio("audio_l ear only", 9'h100, audio_l);
		check_audio("audio_r ear only", 9'h100, audio_r);
		rand_byte(v1);
		rand_byte(v2);
		port_write(sam_pkg::PORT_LPT_DATA, v1);
		port_write(sam_pkg::PORT_LPT_STROBE, 8'h01);  // Rising strobe, left voice
		port_write(sam_pkg::PORT_LPT_DATA, v2);
		port_write(sam_pkg::PORT_LPT_STROBE, 8'h00);
		check_audio("audio_l", {1'b0, v1} + 9'h100, audio_l);
		check_audio("audio_r", {1'b0, v2} + 9'h100, audio_r);
		port_write(sam_pkg::PORT_BORDER, b & 8'hEF);
		check_audio("audio_l no ear", {1'b0, v1}, audio_l);
		check_audio("audio_r no ear", {1'b0, v2}, audio_r);
		end_test();
	endtask

	task automatic test_midi_tx();
		int n;
		logic [7:0] d;
		start_test("midi_tx");
		port_write(sam_pkg::PORT_MIDI, 8'h90);
		n = 0;
		while (midi_busy !== 1'b1 && n < MIDI_WAIT) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		if (midi_busy !== 1'b1)
			abort_run("midi_busy never rose after the MIDI write");
		n = 0;
		while (int_midi !== 1'b1 && n < MIDI_WAIT) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		if (int_midi !== 1'b1)
			abort_run("int_midi never rose during the transmission");
		check_flag("midi_busy at interrupt", 1'b1, midi_busy);
		port_read(sam_pkg::PORT_STATUS, d);
		check_byte("status with interrupt", 8'hEF, d);
		n = 0;
		while (midi_busy !== 1'b0 && n < MIDI_WAIT) begin
			@(posedge clk_sys);
			#1;
			n++;
		end
		if (midi_busy !== 1'b0)
			abort_run("midi_busy never fell after the transmission");
		check_flag("int_midi after end", 1'b0, int_midi);
		port_read(sam_pkg::PORT_STATUS, d);
		check_byte("status idle", 8'hFF, d);
		end_test();
	endtask

	// ============================================================
	// Main sequence
	// ============================================================
	initial begin
		reset       = 1'b1;
		io_req      = 1'b0;
		io_write    = 1'b0;
		io_addr     = '0;
		io_wdata    = '0;
		mem_addr    = '0;
		lfsr        = 17'd88570;
		check_count = 0;
		err_count   = 0;
		test_count  = 0;
		test_errs   = 0;
		repeat (8) @(posedge clk_sys);
		#1;
		reset = 1'b0;
		@(posedge clk_sys);
		#1;
		test_reset_state();
		test_ram_paging();
		test_rom_select();
		test_ext_window();
		test_border_audio();
		test_midi_tx();
		$display("Tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
		if (err_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== sam_asic.f ====
source/sam_pkg.sv
source/sam_bus_port.sv
source/sam_mem_pager.sv
source/sam_sound_ports.sv
source/sam_midi_tx.sv
source/sam_asic.sv
dv/sam_asic_tb.sv

// ==== Bender.yml ====
package:
  name: sam_asic

sources:
  - source/sam_pkg.sv
  - source/sam_bus_port.sv
  - source/sam_mem_pager.sv
  - source/sam_sound_ports.sv
  - source/sam_midi_tx.sv
  - source/sam_asic.sv
  - target: test
    files:
      - dv/sam_asic_tb.sv
